// File: hw/axi_wr_pkg.sv
/*
 * AXI4 write channel fields and stream beat. Only 4-byte beats are supported;
 * the address field is sized for 32 bits and narrower designs leave upper bits zero.
 */
package axi_wr_pkg;

   // Data path is fixed at one 32-bit word per beat
   localparam int AXI_DATA_W = 32;

   // AWLEN field width
   localparam int AXI_LEN_W = 8;

   // Widest address a design may use
   localparam int AXI_ADDR_MAX_W = 32;

   // One word from the stream side
   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
   } axis_beat_t;

   // Write address channel payload, len is beats minus one
   typedef struct packed {
      logic [AXI_ADDR_MAX_W-1:0] addr;
      logic [AXI_LEN_W-1:0]      len;
   } axi_aw_t;

   // Write data channel payload
   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic                  last;
   } axi_w_t;

endpackage

// File: hw/axis2axi_ctrl_pkg.sv
/*
 * Burst controller state encoding and stream configuration.
 * The start address must be word aligned.
 */
package axis2axi_ctrl_pkg;

   // Write sequence of the burst controller
   typedef enum logic [1:0] {
      WAIT_DATA   = 2'd0,
      START_BURST = 2'd1,
      SEND_BEATS  = 2'd2,
      WAIT_BRESP  = 2'd3
   } wr_state_e;

   // Start of a new stream
   typedef struct packed {
      logic [axi_wr_pkg::AXI_ADDR_MAX_W-1:0] addr;
   } cfg_t;

endpackage

// File: hw/axis_burst_fifo.sv
/*
 * Synchronous FIFO, depth 2**ADDR_W. Read data shows up one cycle after r_en_i.
 * Writes while full and reads while empty are dropped.
 */
`timescale 1ns/100ps

module axis_burst_fifo #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 3
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              w_en_i,
   input  logic [DATA_W-1:0] w_data_i,
   output logic              full_o,
   input  logic              r_en_i,
   output logic [DATA_W-1:0] r_data_o,
   output logic              empty_o,
   output logic [ADDR_W:0]   level_o
);

   localparam int DEPTH = 2 ** ADDR_W;
   localparam logic [ADDR_W:0] FULL_LVL = (ADDR_W + 1)'(DEPTH);

   logic [DATA_W-1:0] mem [DEPTH];
   logic [ADDR_W-1:0] wr_ptr_q;
   logic [ADDR_W-1:0] rd_ptr_q;
   logic [ADDR_W:0]   level_q;
   logic              do_write;
   logic              do_read;

   assign do_write = w_en_i && !full_o;
   assign do_read  = r_en_i && !empty_o;

   assign full_o  = (level_q == FULL_LVL);
   assign empty_o = (level_q == '0);
   assign level_o = level_q;

   // Storage
   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[wr_ptr_q] <= w_data_i;
      end
   end

   // Registered read port
   always_ff @(posedge clk_i) begin
      if (do_read) begin
         r_data_o <= mem[rd_ptr_q];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_read) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Simultaneous read and write leaves the level unchanged
         case ({do_write, do_read})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

endmodule

// File: hw/axi_burst_writer.sv
/*
 * Stream to AXI4 INCR bursts of up to 2**BURST_W beats, 4-byte size, single ID.
 * Bursts are clipped at 4 KB when AXI_ADDR_W >= 13. BRESP is not checked.
 */
`timescale 1ns/100ps

module axi_burst_writer #(
   parameter int AXI_ADDR_W = 32,
   parameter int BURST_W    = 2
) (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    cfg_valid_i,
   input  axis2axi_ctrl_pkg::cfg_t cfg_i,
   output logic                    cfg_ready_o,
   input  logic                    axis_valid_i,
   output logic                    axis_ready_o,
   input  axi_wr_pkg::axis_beat_t  axis_i,
   output logic                    aw_valid_o,
   output axi_wr_pkg::axi_aw_t     aw_o,
   input  logic                    aw_ready_i,
   output logic                    w_valid_o,
   output axi_wr_pkg::axi_w_t      w_o,
   input  logic                    w_ready_i,
   input  logic                    b_valid_i
);

   import axi_wr_pkg::*;
   import axis2axi_ctrl_pkg::*;

   // Room for two full bursts
   localparam int FIFO_ADDR_W = BURST_W + 1;
   localparam logic [FIFO_ADDR_W:0] FULL_BURST = (FIFO_ADDR_W + 1)'(2 ** BURST_W);

   wr_state_e              state_q;
   wr_state_e              state_d;
   logic [AXI_ADDR_W-1:0]  addr_q;
   logic [BURST_W:0]       len_q;
   logic [BURST_W:0]       beat_q;
   logic [BURST_W:0]       n_beats;
   logic [BURST_W:0]       burst_size;
   logic [FIFO_ADDR_W:0]   fill_size;
   logic [FIFO_ADDR_W:0]   fifo_level;
   logic [AXI_DATA_W-1:0]  fifo_data;
   logic                   fifo_empty;
   logic                   fifo_full;
   logic                   full_burst_ok;
   logic                   tail_burst_ok;
   logic                   start_burst;
   logic                   w_hs;
   logic                   w_last;
   logic                   fifo_rd;

   assign full_burst_ok = (fifo_level >= FULL_BURST);
   // Stream idle with a partial burst waiting
   assign tail_burst_ok = (fifo_level != '0) && !full_burst_ok && !axis_valid_i;
   assign start_burst   = (state_q == WAIT_DATA) && (full_burst_ok || tail_burst_ok);

   assign fill_size = full_burst_ok ? FULL_BURST : fifo_level;

   generate
      if (AXI_ADDR_W >= 13) begin : g_4k_clip
         logic [12:0] bytes_left;
         logic [10:0] words_left;

         assign bytes_left = 13'h1000 - {1'b0, addr_q[11:0]};
         assign words_left = bytes_left[12:2];

         always_comb begin
            burst_size = fill_size[BURST_W:0];
            if (32'(words_left) < 32'(fill_size)) begin
               burst_size = words_left[BURST_W:0];
            end
         end
      end else begin : g_no_clip
         // Address space smaller than one 4 KB page
         assign burst_size = fill_size[BURST_W:0];
      end
   endgenerate

   assign w_hs    = w_valid_o && w_ready_i;
   assign w_last  = (beat_q == len_q);
   assign n_beats = len_q + 1'b1;

   // First word is prefetched at burst start, then one read per beat but the last
   assign fifo_rd = start_burst || (w_hs && !w_last);

   assign aw_valid_o = (state_q == START_BURST);
   assign aw_o.addr  = AXI_ADDR_MAX_W'(addr_q);
   assign aw_o.len   = AXI_LEN_W'(len_q);

   // The burst never exceeds the FIFO level, so data is always available
   assign w_valid_o = (state_q == SEND_BEATS);
   assign w_o.data  = fifo_data;
   assign w_o.last  = w_last;

   assign axis_ready_o = !fifo_full;
   assign cfg_ready_o  = fifo_empty && (state_q == WAIT_DATA);

   always_comb begin
      state_d = state_q;
      case (state_q)
         WAIT_DATA: begin
            if (start_burst) begin
               state_d = START_BURST;
            end
         end
         START_BURST: begin
            if (aw_ready_i) begin
               state_d = SEND_BEATS;
            end
         end
         SEND_BEATS: begin
            if (w_hs && w_last) begin
               state_d = WAIT_BRESP;
            end
         end
         WAIT_BRESP: begin
            if (b_valid_i) begin
               state_d = WAIT_DATA;
            end
         end
         default: state_d = WAIT_DATA;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= WAIT_DATA;
         addr_q  <= '0;
         len_q   <= '0;
         beat_q  <= '0;
      end else begin
         state_q <= state_d;
         if (cfg_valid_i && cfg_ready_o) begin
            addr_q <= cfg_i.addr[AXI_ADDR_W-1:0];
         end else if (w_hs && w_last) begin
            // Advance by 4 bytes per beat just sent
            addr_q <= addr_q + AXI_ADDR_W'({n_beats, 2'b00});
         end
         if (start_burst) begin
            len_q <= burst_size - 1'b1;
         end
         if (state_q == WAIT_DATA) begin
            beat_q <= '0;
         end else if (w_hs) begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   axis_burst_fifo #(
      .DATA_W(AXI_DATA_W),
      .ADDR_W(FIFO_ADDR_W)
   ) u_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .w_en_i  (axis_valid_i),
      .w_data_i(axis_i.data),
      .full_o  (fifo_full),
      .r_en_i  (fifo_rd),
      .r_data_o(fifo_data),
      .empty_o (fifo_empty),
      .level_o (fifo_level)
   );

endmodule

// File: hw/axis2axi_in_top.sv
/*
 * Stream to AXI4 write bridge. Memory side sees ID 0, INCR, 4-byte beats, full
 * strobes and BREADY tied high. Raise cfg_valid_i only while cfg_ready_o is high.
 */
`timescale 1ns/100ps

module axis2axi_in_top #(
   parameter int AXI_ADDR_W = 32,
   parameter int BURST_W    = 2
) (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    cfg_valid_i,
   input  axis2axi_ctrl_pkg::cfg_t cfg_i,
   output logic                    cfg_ready_o,
   input  logic                    axis_valid_i,
   output logic                    axis_ready_o,
   input  axi_wr_pkg::axis_beat_t  axis_i,
   output logic                    aw_valid_o,
   output axi_wr_pkg::axi_aw_t     aw_o,
   input  logic                    aw_ready_i,
   output logic                    w_valid_o,
   output axi_wr_pkg::axi_w_t      w_o,
   input  logic                    w_ready_i,
   input  logic                    b_valid_i
);

   axi_burst_writer #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .BURST_W   (BURST_W)
   ) u_writer (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_valid_i (cfg_valid_i),
      .cfg_i       (cfg_i),
      .cfg_ready_o (cfg_ready_o),
      .axis_valid_i(axis_valid_i),
      .axis_ready_o(axis_ready_o),
      .axis_i      (axis_i),
      .aw_valid_o  (aw_valid_o),
      .aw_o        (aw_o),
      .aw_ready_i  (aw_ready_i),
      .w_valid_o   (w_valid_o),
      .w_o         (w_o),
      .w_ready_i   (w_ready_i),
      .b_valid_i   (b_valid_i)
   );

endmodule

// File: verification/axis2axi_in_tb.sv
/*
 * Testbench for axis2axi_in_top. Reads verification/axis2axi_in_tests.txt from
 * the project root. Handshakes are sampled on the falling clock edge.
 */
`timescale 1ns/100ps

module axis2axi_in_tb;

   import axi_wr_pkg::*;
   import axis2axi_ctrl_pkg::*;

   localparam int MAX_TESTS  = 16;
   localparam int MAX_BURSTS = 128;

   logic       clk;
   logic       rst_n;
   logic       cfg_valid_i;
   cfg_t       cfg_i;
   logic       cfg_ready_o;
   logic       axis_valid_i;
   logic       axis_ready_o;
   axis_beat_t axis_i;
   logic       aw_valid_o;
   axi_aw_t    aw_o;
   logic       aw_ready_i;
   logic       w_valid_o;
   axi_w_t     w_o;
   logic       w_ready_i;
   logic       b_valid_i;

   // Test table loaded from the data file
   string       t_name  [MAX_TESTS];
   logic [31:0] t_addr  [MAX_TESTS];
   int          t_count [MAX_TESTS];
   logic [31:0] t_base  [MAX_TESTS];
   int          t_stall [MAX_TESTS];
   int          t_first [MAX_TESTS];
   int          t_nburst[MAX_TESTS];
   axi_aw_t     b_list  [MAX_BURSTS];
   int          num_tests;
   int          num_bursts;

   // State of the running test
   string       cur_name;
   int          cur_count;
   logic [31:0] cur_base;
   int          stall_en;
   axi_aw_t     aw_q[$];
   logic [7:0]  cur_len;
   int          beat;
   int          words_seen;
   logic        b_due;
   int          cycle_limit;
   int          cycles;

   axis2axi_in_top #(
      .AXI_ADDR_W(32),
      .BURST_W   (2)
   ) u_dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .cfg_valid_i (cfg_valid_i),
      .cfg_i       (cfg_i),
      .cfg_ready_o (cfg_ready_o),
      .axis_valid_i(axis_valid_i),
      .axis_ready_o(axis_ready_o),
      .axis_i      (axis_i),
      .aw_valid_o  (aw_valid_o),
      .aw_o        (aw_o),
      .aw_ready_i  (aw_ready_i),
      .w_valid_o   (w_valid_o),
      .w_o         (w_o),
      .w_ready_i   (w_ready_i),
      .b_valid_i   (b_valid_i)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_aw(input string name, input axi_aw_t exp, input axi_aw_t act);
      if (exp !== act) begin
         $display("[ERROR] %s: AW expected addr=%h len=%0d, actual addr=%h len=%0d",
                  name, exp.addr, exp.len, act.addr, act.len);
         abort_run("Write address mismatch");
      end
   endtask

   task automatic check_w(input string name, input axi_w_t exp, input axi_w_t act);
      if (exp !== act) begin
         $display("[ERROR] %s: W expected data=%h last=%b, actual data=%h last=%b",
                  name, exp.data, exp.last, act.data, act.last);
         abort_run("Write data mismatch");
      end
   endtask

   task automatic load_tests();
      int          fd;
      string       line;
      string       kw;
      string       nm;
      logic [31:0] a;
      logic [31:0] b;
      int          c;
      int          s;
      int          l;
      fd = $fopen("verification/axis2axi_in_tests.txt", "r");
      if (fd == 0) begin
         abort_run("Could not open the test data file");
      end
      num_tests  = 0;
      num_bursts = 0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") begin
            continue;
         end
         void'($sscanf(line, "%s", kw));
         if (kw == "test") begin
            void'($sscanf(line, "%s %s %h %d %h %d", kw, nm, a, c, b, s));
            t_name[num_tests]   = nm;
            t_addr[num_tests]   = a;
            t_count[num_tests]  = c;
            t_base[num_tests]   = b;
            t_stall[num_tests]  = s;
            t_first[num_tests]  = num_bursts;
            t_nburst[num_tests] = 0;
            num_tests++;
         end else if (kw == "burst") begin
            void'($sscanf(line, "%s %h %d", kw, a, l));
            b_list[num_bursts].addr = a;
            b_list[num_bursts].len  = 8'(l);
            num_bursts++;
            t_nburst[num_tests-1]++;
         end
      end
      $fclose(fd);
      if (num_tests == 0) begin
         abort_run("Test data file holds no tests");
      end
   endtask

   task automatic run_test(input int t);
      logic accepted;
      cur_name   = t_name[t];
      cur_count  = t_count[t];
      cur_base   = t_base[t];
      stall_en   = t_stall[t];
      words_seen = 0;
      for (int k = 0; k < t_nburst[t]; k++) begin
         aw_q.push_back(b_list[t_first[t] + k]);
      end
      @(negedge clk);
      if (!cfg_ready_o) begin
         abort_run($sformatf("%s: bridge not ready for a new start address", cur_name));
      end
      @(posedge clk);
      #1;
      cfg_valid_i = 1'b1;
      cfg_i.addr  = t_addr[t];
      @(posedge clk);
      #1;
      cfg_valid_i = 1'b0;
      for (int i = 0; i < cur_count; i++) begin
         axis_valid_i = 1'b1;
         axis_i.data  = cur_base + 32'(i);
         do begin
            @(negedge clk);
            // Some words are already in the bridge
            if (i > 0 && cfg_ready_o) begin
               abort_run($sformatf("%s: cfg_ready_o high while words remain", cur_name));
            end
            accepted = axis_ready_o;
            @(posedge clk);
            #1;
         end while (!accepted);
      end
      axis_valid_i = 1'b0;
      while (aw_q.size() != 0 || words_seen != cur_count || !cfg_ready_o) begin
         @(negedge clk);
         // Ready returns only after the last response
         if (cfg_ready_o && (aw_q.size() != 0 || words_seen != cur_count ||
                             b_due || b_valid_i)) begin
            abort_run($sformatf("%s: cfg_ready_o high before the final write response",
                                cur_name));
         end
      end
   endtask

   // AXI slave checks on the falling edge
   initial begin
      axi_aw_t exp_aw;
      axi_w_t  exp_w;
      b_due = 1'b0;
      beat  = 0;
      forever begin
         @(negedge clk);
         if (aw_valid_o && aw_ready_i) begin
            if (aw_q.size() == 0) begin
               abort_run($sformatf("%s: burst issued that was not expected", cur_name));
            end
            exp_aw = aw_q.pop_front();
            check_aw(cur_name, exp_aw, aw_o);
            cur_len = exp_aw.len;
            beat    = 0;
         end
         if (w_valid_o && w_ready_i) begin
            if (words_seen >= cur_count) begin
               abort_run($sformatf("%s: more words written than streamed", cur_name));
            end
            exp_w.data = cur_base + 32'(words_seen);
            exp_w.last = (beat == int'(cur_len));
            check_w(cur_name, exp_w, w_o);
            words_seen++;
            beat++;
            if (exp_w.last) begin
               b_due = 1'b1;
            end
         end
      end
   end

   // AXI slave ready and response drive
   initial begin
      forever begin
         @(posedge clk);
         #1;
         b_valid_i = b_due;
         b_due     = 1'b0;
         if (stall_en != 0) begin
            aw_ready_i = ($urandom % 3) != 0;
            w_ready_i  = ($urandom % 3) != 0;
         end else begin
            aw_ready_i = 1'b1;
            w_ready_i  = 1'b1;
         end
      end
   end

   // Watchdog
   initial begin
      cycles = 0;
      wait (cycle_limit > 0);
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, the bridge stopped moving data",
                                cycles));
         end
      end
   end

   initial begin
      int total;
      void'($urandom(32530));
      rst_n        = 1'b0;
      cfg_valid_i  = 1'b0;
      cfg_i        = '0;
      axis_valid_i = 1'b0;
      axis_i       = '0;
      aw_ready_i   = 1'b1;
      w_ready_i    = 1'b1;
      b_valid_i    = 1'b0;
      stall_en     = 0;
      cur_name     = "reset";
      cur_count    = 0;
      cur_base     = '0;
      cur_len      = '0;
      words_seen   = 0;
      cycle_limit  = 0;
      load_tests();
      total = 0;
      for (int t = 0; t < num_tests; t++) begin
         total += t_count[t];
      end
      cycle_limit = total * 20 + 1000;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int t = 0; t < num_tests; t++) begin
         run_test(t);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: axis2axi_in.f
hw/axi_wr_pkg.sv
hw/axis2axi_ctrl_pkg.sv
hw/axis_burst_fifo.sv
hw/axi_burst_writer.sv
hw/axis2axi_in_top.sv
verification/axis2axi_in_tb.sv

// File: Makefile
# Verilator build for the stream to AXI4 write bridge

TB_TOP := axis2axi_in_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f axis2axi_in.f --top-module $(TB_TOP)
	verilator --lint-only hw/axi_wr_pkg.sv hw/axis2axi_ctrl_pkg.sv hw/axis_burst_fifo.sv \
		hw/axi_burst_writer.sv hw/axis2axi_in_top.sv --top-module axis2axi_in_top

sim:
	verilator --binary --timing -f axis2axi_in.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/axis2axi_in_tests.txt
# test  <name> <start addr hex> <word count> <data base hex> <stall 0/1>
# burst <expected AWADDR hex> <expected AWLEN>

# Four full bursts at consecutive addresses
test full_bursts 1000 16 100 0
burst 1000 3
burst 1010 3
burst 1020 3
burst 1030 3

# Short burst once the stream goes idle
test tail_drain 3000 6 200 0
burst 3000 3
burst 3010 1

# Split at the 4 KB page end
test boundary_4k 1ff8 8 300 0
burst 1ff8 1
burst 2000 3
burst 2010 1

# Same split as the first test under random AW and W stalls
test back_pressure 1000 16 400 1
burst 1000 3
burst 1010 3
burst 1020 3
burst 1030 3
